/* common/mcu_cmd_pkg.sv */
package mcu_cmd_pkg;

  // command byte values, first byte of every frame
  typedef enum logic [7:0] {
    cmd_status  = 8'd0,
    cmd_leds    = 8'd1,
    cmd_color   = 8'd2,
    cmd_buttons = 8'd3,
    cmd_config  = 8'd4,
    cmd_irq     = 8'd5
  } cmd_t;

  // signature returned by the status command
  // a pattern unlikely to show up on an unconfigured device
  localparam logic [7:0] status_sig0 = 8'h5c;
  localparam logic [7:0] status_sig1 = 8'h42;

  // width of one reply byte on miso
  localparam int reply_w = 8;

  // byte position inside a frame
  // 0 is the command byte, arguments follow
  typedef logic [3:0] byte_idx_t;

  // position counter stops here on long frames
  localparam byte_idx_t byte_idx_max = 4'd15;

endpackage

/* common/sys_cfg_pkg.sv */
package sys_cfg_pkg;

  // one-character ids that select a config field
  localparam logic [7:0] id_reset     = "R";
  localparam logic [7:0] id_scanlines = "S";
  localparam logic [7:0] id_volume    = "A";
  localparam logic [7:0] id_wide      = "W";
  localparam logic [7:0] id_port1     = "Q";
  localparam logic [7:0] id_port2     = "J";
  localparam logic [7:0] id_turbo     = "X";
  localparam logic [7:0] id_video_std = "E";
  localparam logic [7:0] id_pause     = "G";
  localparam logic [7:0] id_vic       = "I";

  // field widths, value bytes are cut to these low bits
  localparam int reset_w     = 2;
  localparam int scanlines_w = 2;
  localparam int volume_w    = 2;
  localparam int wide_w      = 1;
  localparam int port1_w     = 3;
  localparam int port2_w     = 3;
  localparam int turbo_w     = 2;
  localparam int video_std_w = 1;
  localparam int pause_w     = 1;
  localparam int vic_w       = 2;

  // power-up values until the MCU sends its own
  localparam logic [reset_w-1:0]     def_reset     = '0;
  localparam logic [scanlines_w-1:0] def_scanlines = '0;
  // volume at 66%
  localparam logic [volume_w-1:0]    def_volume    = 2'd2;
  localparam logic [wide_w-1:0]      def_wide      = '0;
  // port 1 starts with no device attached
  localparam logic [port1_w-1:0]     def_port1     = 3'd7;
  localparam logic [port2_w-1:0]     def_port2     = '0;
  localparam logic [turbo_w-1:0]     def_turbo     = '0;
  localparam logic [video_std_w-1:0] def_video_std = '0;
  localparam logic [pause_w-1:0]     def_pause     = '0;
  localparam logic [vic_w-1:0]       def_vic       = '0;

endpackage

/* compile.f */
common/mcu_cmd_pkg.sv
common/sys_cfg_pkg.sv
mcu_link/mcu_spi_slave.sv
hw/sysctrl.sv
hw/irq_ctrl.sv
hw/mcu_ctrl_top.sv
tb/tb_mcu_ctrl.sv

/* hw/irq_ctrl.sv */
`timescale 1ns/1ps

module irq_ctrl (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   byte_strobe,
  input  logic                   byte_start,
  input  logic [7:0]             byte_data,
  input  mcu_cmd_pkg::byte_idx_t byte_idx,
  input  logic [7:0]             int_in,
  output logic [7:0]             reply,
  output logic [7:0]             int_ack,
  output logic                   int_out_n
);
  import mcu_cmd_pkg::*;

  cmd_t command;
  // tells the MCU the FPGA came up from a fresh load
  logic cold_boot;

  // request line to the MCU, active low
  assign int_out_n = ~((|int_in) | cold_boot);

  always_ff @(posedge clk) begin
    if (reset) begin
      command   <= cmd_status;
      reply     <= 8'h00;
      int_ack   <= 8'h00;
      cold_boot <= 1'b1;
    end else begin
      // ack is a single-cycle pulse
      int_ack <= 8'h00;
      // bit 0 of an ack retires the cold-boot notice
      if (int_ack[0])
        cold_boot <= 1'b0;
      if (byte_strobe) begin
        reply <= 8'h00;
        if (byte_start) begin
          command <= cmd_t'(byte_data);
        end else if (command == cmd_irq) begin
          // interrupt state with cold boot in bit 0
          reply <= {int_in[7:1], cold_boot};
          // first argument acknowledges
          if (byte_idx == 4'd1)
            int_ack <= byte_data;
        end
      end
    end
  end

endmodule

/* hw/mcu_ctrl_top.sv */
`timescale 1ns/1ps

module mcu_ctrl_top #(
  parameter logic [7:0] core_id = 8'd2
) (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  spi_cs_n,
  input  logic                                  spi_sclk,
  input  logic                                  spi_mosi,
  output logic                                  spi_miso,
  input  logic [1:0]                            buttons,
  input  logic [7:0]                            int_in,
  output logic [7:0]                            int_ack,
  output logic                                  int_out_n,
  output logic [1:0]                            leds,
  output logic [23:0]                           color,
  output logic [sys_cfg_pkg::reset_w-1:0]       system_reset,
  output logic [sys_cfg_pkg::scanlines_w-1:0]   system_scanlines,
  output logic [sys_cfg_pkg::volume_w-1:0]      system_volume,
  output logic [sys_cfg_pkg::wide_w-1:0]        system_wide_screen,
  output logic [sys_cfg_pkg::port1_w-1:0]       system_port_1,
  output logic [sys_cfg_pkg::port2_w-1:0]       system_port_2,
  output logic [sys_cfg_pkg::turbo_w-1:0]       system_turbo_mode,
  output logic [sys_cfg_pkg::video_std_w-1:0]   system_video_std,
  output logic [sys_cfg_pkg::pause_w-1:0]       system_pause,
  output logic [sys_cfg_pkg::vic_w-1:0]         system_vic_variant
);

  // byte stream shared by both command blocks
  logic                   byte_strobe;
  logic                   byte_start;
  logic [7:0]             byte_data;
  mcu_cmd_pkg::byte_idx_t byte_idx;
  // each block answers only its own commands, the slave ORs them
  logic [7:0]             sys_reply;
  logic [7:0]             irq_reply;

  mcu_spi_slave i_spi (
    .clk         (clk),
    .reset       (reset),
    .spi_cs_n    (spi_cs_n),
    .spi_sclk    (spi_sclk),
    .spi_mosi    (spi_mosi),
    .spi_miso    (spi_miso),
    .sys_reply   (sys_reply),
    .irq_reply   (irq_reply),
    .byte_strobe (byte_strobe),
    .byte_start  (byte_start),
    .byte_data   (byte_data),
    .byte_idx    (byte_idx)
  );

  sysctrl #(
    .core_id (core_id)
  ) i_sysctrl (
    .clk                (clk),
    .reset              (reset),
    .byte_strobe        (byte_strobe),
    .byte_start         (byte_start),
    .byte_data          (byte_data),
    .byte_idx           (byte_idx),
    .buttons            (buttons),
    .reply              (sys_reply),
    .leds               (leds),
    .color              (color),
    .system_reset       (system_reset),
    .system_scanlines   (system_scanlines),
    .system_volume      (system_volume),
    .system_wide_screen (system_wide_screen),
    .system_port_1      (system_port_1),
    .system_port_2      (system_port_2),
    .system_turbo_mode  (system_turbo_mode),
    .system_video_std   (system_video_std),
    .system_pause       (system_pause),
    .system_vic_variant (system_vic_variant)
  );

  irq_ctrl i_irq (
    .clk         (clk),
    .reset       (reset),
    .byte_strobe (byte_strobe),
    .byte_start  (byte_start),
    .byte_data   (byte_data),
    .byte_idx    (byte_idx),
    .int_in      (int_in),
    .reply       (irq_reply),
    .int_ack     (int_ack),
    .int_out_n   (int_out_n)
  );

endmodule

/* hw/sysctrl.sv */
`timescale 1ns/1ps

module sysctrl #(
  parameter logic [7:0] core_id = 8'd2
) (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  byte_strobe,
  input  logic                                  byte_start,
  input  logic [7:0]                            byte_data,
  input  mcu_cmd_pkg::byte_idx_t                byte_idx,
  input  logic [1:0]                            buttons,
  output logic [7:0]                            reply,
  output logic [1:0]                            leds,
  output logic [23:0]                           color,
  output logic [sys_cfg_pkg::reset_w-1:0]       system_reset,
  output logic [sys_cfg_pkg::scanlines_w-1:0]   system_scanlines,
  output logic [sys_cfg_pkg::volume_w-1:0]      system_volume,
  output logic [sys_cfg_pkg::wide_w-1:0]        system_wide_screen,
  output logic [sys_cfg_pkg::port1_w-1:0]       system_port_1,
  output logic [sys_cfg_pkg::port2_w-1:0]       system_port_2,
  output logic [sys_cfg_pkg::turbo_w-1:0]       system_turbo_mode,
  output logic [sys_cfg_pkg::video_std_w-1:0]   system_video_std,
  output logic [sys_cfg_pkg::pause_w-1:0]       system_pause,
  output logic [sys_cfg_pkg::vic_w-1:0]         system_vic_variant
);
  import mcu_cmd_pkg::*;
  import sys_cfg_pkg::*;

  cmd_t       command;
  logic [7:0] cfg_id;
  logic [7:0] data_rev;
  logic [1:0] btn_meta;
  logic [1:0] btn_sync;
  logic       arg_strobe;

  // argument bytes only, the command byte is handled apart
  assign arg_strobe = byte_strobe & ~byte_start;

  // color bytes arrive lsb first
  always_comb begin
    for (int i = 0; i < 8; i++)
      data_rev[i] = byte_data[7 - i];
  end

  // buttons come straight from the board pins
  always_ff @(posedge clk) begin
    btn_meta <= buttons;
    btn_sync <= btn_meta;
  end

  // config id byte, used by the value byte that follows
  always_ff @(posedge clk) begin
    if (arg_strobe && command == cmd_config && byte_idx == 4'd1)
      cfg_id <= byte_data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      command            <= cmd_status;
      reply              <= 8'h00;
      leds               <= 2'b00;
      color              <= 24'h000000;
      system_reset       <= def_reset;
      system_scanlines   <= def_scanlines;
      system_volume      <= def_volume;
      system_wide_screen <= def_wide;
      system_port_1      <= def_port1;
      system_port_2      <= def_port2;
      system_turbo_mode  <= def_turbo;
      system_video_std   <= def_video_std;
      system_pause       <= def_pause;
      system_vic_variant <= def_vic;
    end else if (byte_strobe) begin
      // nothing to say unless a command below answers
      reply <= 8'h00;
      if (byte_start) begin
        command <= cmd_t'(byte_data);
      end else begin
        case (command)
          cmd_status: begin
            case (byte_idx)
              4'd1:    reply <= status_sig0;
              4'd2:    reply <= status_sig1;
              4'd3:    reply <= core_id;
              default: reply <= 8'h00;
            endcase
          end
          cmd_leds: begin
            if (byte_idx == 4'd1)
              leds <= byte_data[1:0];
          end
          // green, blue, then red
          cmd_color: begin
            case (byte_idx)
              4'd1:    color[15:8]  <= data_rev;
              4'd2:    color[7:0]   <= data_rev;
              4'd3:    color[23:16] <= data_rev;
              default: color        <= color;
            endcase
          end
          // answered on every argument byte
          cmd_buttons: reply <= {{(reply_w - 2){1'b0}}, btn_sync};
          cmd_config: begin
            if (byte_idx == 4'd2) begin
              // unknown ids fall through and leave every field alone
              case (cfg_id)
                id_reset:     system_reset       <= byte_data[reset_w-1:0];
                id_scanlines: system_scanlines   <= byte_data[scanlines_w-1:0];
                id_volume:    system_volume      <= byte_data[volume_w-1:0];
                id_wide:      system_wide_screen <= byte_data[wide_w-1:0];
                id_port1:     system_port_1      <= byte_data[port1_w-1:0];
                id_port2:     system_port_2      <= byte_data[port2_w-1:0];
                id_turbo:     system_turbo_mode  <= byte_data[turbo_w-1:0];
                id_video_std: system_video_std   <= byte_data[video_std_w-1:0];
                id_pause:     system_pause       <= byte_data[pause_w-1:0];
                id_vic:       system_vic_variant <= byte_data[vic_w-1:0];
                default:      reply              <= 8'h00;
              endcase
            end
          end
          // irq command and unknown codes belong elsewhere
          default: reply <= 8'h00;
        endcase
      end
    end
  end

endmodule

/* mcu_link/mcu_spi_slave.sv */
`timescale 1ns/1ps

module mcu_spi_slave (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   spi_cs_n,
  input  logic                   spi_sclk,
  input  logic                   spi_mosi,
  output logic                   spi_miso,
  input  logic [7:0]             sys_reply,
  input  logic [7:0]             irq_reply,
  output logic                   byte_strobe,
  output logic                   byte_start,
  output logic [7:0]             byte_data,
  output mcu_cmd_pkg::byte_idx_t byte_idx
);
  import mcu_cmd_pkg::*;

  logic [1:0] cs_sync;
  logic [1:0] sclk_sync;
  logic [1:0] mosi_sync;
  logic       sclk_prev;
  logic       cs_idle;
  logic       sclk_rise;
  logic       sclk_fall;
  logic [2:0] bit_cnt;
  logic [7:0] rx_shift;
  logic       byte_done;
  logic       done_d;
  logic       reply_load;
  logic [7:0] tx_shift;

  // two-flop synchronizers, idle bus is cs high and sclk low
  always_ff @(posedge clk) begin
    if (reset) begin
      cs_sync   <= 2'b11;
      sclk_sync <= 2'b00;
      mosi_sync <= 2'b00;
      sclk_prev <= 1'b0;
    end else begin
      cs_sync   <= {cs_sync[0], spi_cs_n};
      sclk_sync <= {sclk_sync[0], spi_sclk};
      mosi_sync <= {mosi_sync[0], spi_mosi};
      sclk_prev <= sclk_sync[1];
    end
  end

  assign cs_idle   = cs_sync[1];
  assign sclk_rise = sclk_sync[1] & ~sclk_prev;
  assign sclk_fall = ~sclk_sync[1] & sclk_prev;

  // mode 0: sample mosi on rising sclk, msb first
  always_ff @(posedge clk) begin
    if (!cs_idle && sclk_rise)
      rx_shift <= {rx_shift[6:0], mosi_sync[1]};
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      bit_cnt     <= 3'd0;
      byte_done   <= 1'b0;
      done_d      <= 1'b0;
      byte_strobe <= 1'b0;
      byte_start  <= 1'b0;
      byte_idx    <= '0;
    end else begin
      // eighth bit in, strobe leaves two stages later
      byte_done   <= ~cs_idle & sclk_rise & (bit_cnt == 3'd7);
      done_d      <= byte_done;
      byte_strobe <= done_d;
      // position 0 is always the command byte
      byte_start  <= done_d & (byte_idx == '0);
      if (cs_idle)
        bit_cnt <= 3'd0;
      else if (sclk_rise)
        bit_cnt <= bit_cnt + 3'd1;
      // frame position, saturates on long frames
      if (cs_idle)
        byte_idx <= '0;
      else if (byte_strobe && byte_idx != byte_idx_max)
        byte_idx <= byte_idx + 4'd1;
    end
  end

  // byte handed to the command blocks with the strobe
  always_ff @(posedge clk) begin
    if (done_d)
      byte_data <= rx_shift;
  end

  // replies are registered one cycle after the strobe,
  // so take them on the next edge
  // bit_cnt is back at 0 on the fall that closes a byte
  // and that fall must not push out the new reply
  always_ff @(posedge clk) begin
    if (reset) begin
      reply_load <= 1'b0;
      tx_shift   <= 8'h00;
    end else begin
      reply_load <= byte_strobe;
      if (cs_idle)
        tx_shift <= 8'h00;
      else if (reply_load)
        tx_shift <= sys_reply | irq_reply;
      else if (sclk_fall && bit_cnt != 3'd0)
        tx_shift <= {tx_shift[6:0], 1'b0};
    end
  end

  // msb is on the pin as soon as the reply is loaded
  assign spi_miso = tx_shift[7];

endmodule

/* run.sh */
#!/bin/sh
# build the MCU link testbench with Verilator and run it
# the run counts as passed only if the log holds the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_mcu_ctrl -f compile.f -o sim_mcu_ctrl || exit 1
./obj_dir/sim_mcu_ctrl > sim.log 2>&1
cat sim.log
grep -q "^TEST PASSED$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* tb/tb_mcu_ctrl.sv */
`timescale 1ns/1ps

module tb_mcu_ctrl;
  import mcu_cmd_pkg::*;
  import sys_cfg_pkg::*;

  localparam logic [7:0] tb_core_id = 8'h17;
  localparam int clk_period = 10;
  // sclk phase in clk cycles
  localparam int half_cycles = 5;
  localparam int gap_cycles = 4;
  // longest frame is the status read with five bytes
  localparam int max_bytes = 5;
  localparam int frame_cycles = max_bytes * (16 * half_cycles + gap_cycles) + 16;
  // status, leds, color, buttons, 11 config, 3 irq
  localparam int n_frames = 18;
  localparam int timeout_ns = n_frames * frame_cycles * 2 * clk_period;

  // config fields in one fixed order
  localparam logic [7:0] cfg_ids [10] = '{id_reset, id_scanlines, id_volume, id_wide,
    id_port1, id_port2, id_turbo, id_video_std, id_pause, id_vic};
  localparam int cfg_w [10] = '{reset_w, scanlines_w, volume_w, wide_w, port1_w,
    port2_w, turbo_w, video_std_w, pause_w, vic_w};
  localparam logic [7:0] cfg_def [10] = '{8'(def_reset), 8'(def_scanlines),
    8'(def_volume), 8'(def_wide), 8'(def_port1), 8'(def_port2), 8'(def_turbo),
    8'(def_video_std), 8'(def_pause), 8'(def_vic)};

  logic                   clk;
  logic                   reset;
  logic                   spi_cs_n;
  logic                   spi_sclk;
  logic                   spi_mosi;
  logic                   spi_miso;
  logic [1:0]             buttons;
  logic [7:0]             int_in;
  logic [7:0]             int_ack;
  logic                   int_out_n;
  logic [1:0]             leds;
  logic [23:0]            color;
  logic [reset_w-1:0]     system_reset;
  logic [scanlines_w-1:0] system_scanlines;
  logic [volume_w-1:0]    system_volume;
  logic [wide_w-1:0]      system_wide_screen;
  logic [port1_w-1:0]     system_port_1;
  logic [port2_w-1:0]     system_port_2;
  logic [turbo_w-1:0]     system_turbo_mode;
  logic [video_std_w-1:0] system_video_std;
  logic [pause_w-1:0]     system_pause;
  logic [vic_w-1:0]       system_vic_variant;

  // bytes of one frame, out on mosi and back from miso
  logic [7:0] tx_buf [8];
  logic [7:0] rx_buf [8];
  logic [7:0] cfg_now [10];
  logic [7:0] exp_cfg [10];
  logic       exp_cold;
  logic       exp_irq_n;
  int         ack_count;
  logic [7:0] ack_seen;

  mcu_ctrl_top #(.core_id(tb_core_id)) i_dut (.*);

  assign cfg_now[0] = 8'(system_reset);
  assign cfg_now[1] = 8'(system_scanlines);
  assign cfg_now[2] = 8'(system_volume);
  assign cfg_now[3] = 8'(system_wide_screen);
  assign cfg_now[4] = 8'(system_port_1);
  assign cfg_now[5] = 8'(system_port_2);
  assign cfg_now[6] = 8'(system_turbo_mode);
  assign cfg_now[7] = 8'(system_video_std);
  assign cfg_now[8] = 8'(system_pause);
  assign cfg_now[9] = 8'(system_vic_variant);

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(timeout_ns);
    $display("watchdog expired before all frames were sent");
    $display("TEST FAILED");
    $fatal(1);
  end

  // count ack pulses between edges
  always @(negedge clk) begin
    if (!reset && int_ack != 8'h00) begin
      ack_count = ack_count + 1;
      ack_seen = int_ack;
    end
  end

  // an ack never lasts a second cycle
  ack_single: assert property (@(posedge clk) disable iff (reset)
      (int_ack != 8'h00) |=> (int_ack == 8'h00))
    else begin
      $display("ERR int_ack still 0x%0h one cycle after its pulse", int_ack);
      $display("TEST FAILED");
      $fatal(1);
    end

  // any pending input pulls the request line
  irq_request: assert property (@(posedge clk) disable iff (reset)
      (int_in != 8'h00) |-> (int_out_n == 1'b0))
    else begin
      $display("ERR int_out_n 0x%0h with int_in 0x%0h", int_out_n, int_in);
      $display("TEST FAILED");
      $fatal(1);
    end

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  function automatic logic [7:0] reverse_bits(input logic [7:0] b);
    return {b[0], b[1], b[2], b[3], b[4], b[5], b[6], b[7]};
  endfunction

  function automatic string field_name(input int f);
    case (f)
      0:       return "system_reset";
      1:       return "system_scanlines";
      2:       return "system_volume";
      3:       return "system_wide_screen";
      4:       return "system_port_1";
      5:       return "system_port_2";
      6:       return "system_turbo_mode";
      7:       return "system_video_std";
      8:       return "system_pause";
      default: return "system_vic_variant";
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
    else begin
      $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_config();
    for (int f = 0; f < 10; f++)
      check_value(field_name(f), 32'(cfg_now[f]), 32'(exp_cfg[f]));
  endtask

  // mode 0 byte, msb first, miso taken as sclk rises
  task automatic shift_byte(input logic [7:0] tx, output logic [7:0] rx);
    for (int i = 7; i >= 0; i--) begin
      spi_mosi = tx[i];
      wait_cycles(half_cycles);
      spi_sclk = 1'b1;
      rx[i] = spi_miso;
      wait_cycles(half_cycles);
      spi_sclk = 1'b0;
    end
    wait_cycles(gap_cycles);
  endtask

  task automatic send_frame(input int n_bytes);
    logic [7:0] got;
    spi_cs_n = 1'b0;
    for (int k = 0; k < n_bytes; k++) begin
      shift_byte(tx_buf[k], got);
      rx_buf[k] = got;
    end
    // let the last strobe settle before cs rises
    wait_cycles(8);
    spi_cs_n = 1'b1;
    wait_cycles(8);
  endtask

  initial begin
    logic [7:0] value;
    logic [7:0] ack;
    logic [7:0] b1;
    logic [7:0] b2;
    logic [7:0] b3;
    void'($urandom(32'ha9bbfc64));
    reset = 1'b1;
    spi_cs_n = 1'b1;
    spi_sclk = 1'b0;
    spi_mosi = 1'b0;
    buttons = 2'b00;
    int_in = 8'h00;
    ack_count = 0;
    ack_seen = 8'h00;
    exp_cold = 1'b1;
    exp_cfg = cfg_def;
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    wait_cycles(2);

    // idle state after reset
    check_value("leds", 32'(leds), 32'h0);
    check_value("color", 32'(color), 32'h0);
    check_value("int_ack", 32'(int_ack), 32'h0);
    check_value("int_out_n", 32'(int_out_n), 32'h0);
    check_value("spi_miso", 32'(spi_miso), 32'h0);
    check_config();

    // status read, each reply shows up one byte late
    tx_buf[0] = cmd_status;
    for (int k = 1; k < 5; k++)
      tx_buf[k] = 8'($urandom);
    send_frame(5);
    check_value("spi_miso byte 0", 32'(rx_buf[0]), 32'h0);
    check_value("spi_miso byte 1", 32'(rx_buf[1]), 32'h0);
    check_value("spi_miso byte 2", 32'(rx_buf[2]), 32'(status_sig0));
    check_value("spi_miso byte 3", 32'(rx_buf[3]), 32'(status_sig1));
    check_value("spi_miso byte 4", 32'(rx_buf[4]), 32'(tb_core_id));

    // leds take the low two bits
    value = 8'($urandom);
    // at least one led bit set so the write is visible
    if (value[1:0] == 2'b00)
      value[0] = 1'b1;
    tx_buf[0] = cmd_leds;
    tx_buf[1] = value;
    send_frame(2);
    check_value("leds", 32'(leds), 32'(value[1:0]));

    // color bytes come green, blue, red and each one reversed
    b1 = 8'($urandom);
    b2 = 8'($urandom);
    b3 = 8'($urandom);
    tx_buf[0] = cmd_color;
    tx_buf[1] = b1;
    tx_buf[2] = b2;
    tx_buf[3] = b3;
    send_frame(4);
    check_value("color", 32'(color),
                32'({reverse_bits(b3), reverse_bits(b1), reverse_bits(b2)}));

    // buttons held steady through their synchronizer
    buttons = 2'($urandom);
    // at least one button pressed
    if (buttons == 2'b00)
      buttons = 2'b01;
    wait_cycles(4);
    tx_buf[0] = cmd_buttons;
    tx_buf[1] = 8'h00;
    tx_buf[2] = 8'h00;
    send_frame(3);
    check_value("spi_miso byte 2", 32'(rx_buf[2]), 32'({6'b000000, buttons}));

    // every id in turn, only its own field moves
    for (int f = 0; f < 10; f++) begin
      value = 8'($urandom);
      // flip bit 0 when the value would leave the field as it is
      if ((value & 8'((1 << cfg_w[f]) - 1)) == exp_cfg[f])
        value[0] = ~value[0];
      tx_buf[0] = cmd_config;
      tx_buf[1] = cfg_ids[f];
      tx_buf[2] = value;
      send_frame(3);
      exp_cfg[f] = value & 8'((1 << cfg_w[f]) - 1);
      check_config();
    end
    // "Z" is not a config id
    tx_buf[0] = cmd_config;
    tx_buf[1] = 8'h5a;
    tx_buf[2] = 8'($urandom);
    send_frame(3);
    check_config();

    // ack without bit 0 keeps the cold-boot flag
    int_in = 8'($urandom);
    ack = (8'($urandom) & 8'hfe) | 8'h02;
    ack_count = 0;
    tx_buf[0] = cmd_irq;
    tx_buf[1] = ack;
    tx_buf[2] = 8'h00;
    send_frame(3);
    check_value("spi_miso byte 2", 32'(rx_buf[2]), 32'({int_in[7:1], exp_cold}));
    check_value("int_ack pulse count", 32'(ack_count), 32'd1);
    check_value("int_ack", 32'(ack_seen), 32'(ack));
    check_value("int_out_n", 32'(int_out_n), 32'h0);

    // ack of bit 0 with no inputs releases the request line
    int_in = 8'h00;
    ack_count = 0;
    tx_buf[1] = 8'h01;
    send_frame(3);
    check_value("spi_miso byte 2", 32'(rx_buf[2]), 32'({7'b0000000, exp_cold}));
    check_value("int_ack pulse count", 32'(ack_count), 32'd1);
    check_value("int_ack", 32'(ack_seen), 32'h01);
    exp_cold = 1'b0;
    check_value("int_out_n", 32'(int_out_n), 32'h1);

    // flag stays clear, a zero ack gives no pulse
    int_in = 8'($urandom);
    ack_count = 0;
    tx_buf[1] = 8'h00;
    send_frame(3);
    check_value("spi_miso byte 2", 32'(rx_buf[2]), 32'({int_in[7:1], exp_cold}));
    check_value("int_ack pulse count", 32'(ack_count), 32'd0);
    exp_irq_n = ~((|int_in) | exp_cold);
    check_value("int_out_n", 32'(int_out_n), 32'(exp_irq_n));

    $display("TEST PASSED");
    $finish;
  end

endmodule
